//--- compile.f
+incdir+verif
rtl/arb_cfg_pkg.sv
rtl/arb_types_pkg.sv
rtl/arb_sched_if.sv
rtl/arb_req_detect.sv
rtl/arb_psr_queue.sv
rtl/arb_completion.sv
rtl/tx_arbiter_top.sv
verif/arb_tb.sv

//--- rtl/arb_cfg_pkg.sv
//////////////////////////////////////////////////
// TX arbiter configuration
// Channel count, request queue sizing and the
// bit position of each channel in a request vector
//////////////////////////////////////////////////

package arb_cfg_pkg;

  // Source channels RW, CC, CFG and RR
  localparam int NUM_CH = 4;

  // Worst case is three other channels requesting on
  // separate cycles while one channel is in service
  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = 2;   // Wraps naturally at QUEUE_DEPTH

  // Request vector layout, lowest priority at bit 0
  localparam int BIT_RR  = 0;
  localparam int BIT_CFG = 1;
  localparam int BIT_CC  = 2;
  localparam int BIT_RW  = 3;       // Highest priority

endpackage : arb_cfg_pkg

//--- rtl/arb_completion.sv
//////////////////////////////////////////////////
// TX arbiter completion tracker
// Flags the end of the granted packet and raises
// throttle when a channel wants back-to-back
// service while other work waits
//////////////////////////////////////////////////

`timescale 1ns/1ps

module arb_completion
  import arb_cfg_pkg::*, arb_types_pkg::*;
(
  input  logic        com_iclk,
  input  logic        com_sysrst,
  input  logic        rw_tvalid,
  input  logic        cc_tvalid,
  input  logic        cfg_tvalid,
  input  logic        rr_tvalid,
  input  logic        rw_tlast,
  input  logic        cc_tlast,
  input  logic        cfg_tlast,
  input  logic        rr_tlast,
  input  logic        tx_tready,
  arb_sched_if.done   sched,
  output logic        rr_thrtl,
  output logic        rw_thrtl,
  output logic        cc_thrtl
);

  req_vec_t sel_vec;
  req_vec_t last_beat;    // tvalid and tlast per channel
  logic     done_nxt;
  logic     thrtl_en;     // Completion with more work queued

  assign last_beat[BIT_RW]  = rw_tvalid  & rw_tlast;
  assign last_beat[BIT_CC]  = cc_tvalid  & cc_tlast;
  assign last_beat[BIT_CFG] = cfg_tvalid & cfg_tlast;
  assign last_beat[BIT_RR]  = rr_tvalid  & rr_tlast;

  assign sel_vec  = sel_to_vec(sched.channel_sel);
  assign done_nxt = tx_tready && ((sel_vec & last_beat) != '0);  // Last beat accepted

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      sched.req_done <= 1'b0;
    end else begin
      sched.req_done <= done_nxt;
    end
  end

  assign thrtl_en = sched.req_done && sched.backlog;

  // Hold off a channel that just finished and requests again at once
  assign rw_thrtl = thrtl_en && (sched.channel_sel == CH_RW) && sched.pkt_req[BIT_RW];
  assign cc_thrtl = thrtl_en && (sched.channel_sel == CH_CC) && sched.pkt_req[BIT_CC];
  assign rr_thrtl = thrtl_en && (sched.channel_sel == CH_RR) && sched.pkt_req[BIT_RR];

endmodule : arb_completion

//--- rtl/arb_psr_queue.sv
//////////////////////////////////////////////////
// TX arbiter status register and request queue
// Holds the pending request set, buffers later
// requests in a small queue and picks the channel
// by fixed priority RW, CC, CFG, RR
//////////////////////////////////////////////////

`timescale 1ns/1ps

module arb_psr_queue
  import arb_cfg_pkg::*, arb_types_pkg::*;
(
  input  logic         com_iclk,
  input  logic         com_sysrst,
  input  logic         lnk_up,
  arb_sched_if.queue   sched
);

  req_vec_t            psr;                    // Packet status register
  req_vec_t            psr_nxt;
  req_vec_t            clr_vec;                // Bit of the channel just served
  req_vec_t            fifo_q [QUEUE_DEPTH];   // Pending request vectors
  logic [QPTR_W-1:0]   rd_ptr;
  logic [QPTR_W-1:0]   wr_ptr;
  logic                fifo_empty;
  logic                psr_idle_w;
  logic                psr_single;             // Exactly one request left in PSR
  logic                pkt_any;
  logic                push_en;
  logic                pop_en;

  assign fifo_empty = (rd_ptr == wr_ptr);
  assign psr_idle_w = (psr == '0);
  assign psr_single = $onehot(psr);
  assign pkt_any    = (sched.pkt_req != '0);

  // Served bit to drop on a multi-request completion
  // CFG and RR both map to the RR bit in endpoint mode
  always_comb begin
    clr_vec = '0;
    case (sched.channel_sel)
      CH_RW:   clr_vec[BIT_RW] = 1'b1;
      CH_CC:   clr_vec[BIT_CC] = 1'b1;
      default: clr_vec[BIT_RR] = 1'b1;
    endcase
  end

  // Next PSR value and queue push/pop
  always_comb begin
    psr_nxt = psr;
    push_en = 1'b0;
    pop_en  = 1'b0;
    if (fifo_empty) begin
      if (psr_idle_w && pkt_any) begin
        psr_nxt = sched.pkt_req;                 // Idle, take request directly
      end else if (sched.req_done && psr_single) begin
        psr_nxt = sched.pkt_req;                 // Last pending one served
      end else if (sched.req_done) begin
        psr_nxt = lnk_up ? (psr & ~clr_vec) : '0; // Others pending, drop served bit
        push_en = pkt_any;
      end else if (!psr_idle_w && pkt_any) begin
        push_en = 1'b1;                          // Busy, park the new request
      end
    end else begin
      if (sched.req_done && psr_single) begin
        psr_nxt = fifo_q[rd_ptr];                // Oldest queued set
        pop_en  = 1'b1;
      end else if (sched.req_done) begin
        psr_nxt = psr & ~clr_vec;
      end
      push_en = pkt_any;                         // Queue in use, always append
    end
  end

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      psr <= '0;
    end else begin
      psr <= psr_nxt;
    end
  end

  // Queue pointers, emptied on link down
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
    end else if (!lnk_up) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
    end else begin
      if (pop_en) begin
        rd_ptr <= rd_ptr + QPTR_W'(1);
      end
      if (push_en) begin
        wr_ptr <= wr_ptr + QPTR_W'(1);
      end
    end
  end

  // Queue storage
  always_ff @(posedge com_iclk) begin
    if (push_en) begin
      fifo_q[wr_ptr] <= sched.pkt_req;
    end
  end

  // Fixed priority select, RW is the idle default
  always_comb begin
    if (psr[BIT_RW]) begin
      sched.channel_sel = CH_RW;
    end else if (psr[BIT_CC]) begin
      sched.channel_sel = CH_CC;
    end else if (psr[BIT_CFG]) begin
      sched.channel_sel = CH_CFG;
    end else if (psr[BIT_RR]) begin
      sched.channel_sel = CH_RR;
    end else begin
      sched.channel_sel = CH_RW;
    end
  end

  assign sched.backlog  = !fifo_empty || (!psr_idle_w && !psr_single);
  assign sched.psr_idle = psr_idle_w;

endmodule : arb_psr_queue

//--- rtl/arb_req_detect.sv
//////////////////////////////////////////////////
// TX arbiter request detector
// Turns tvalid edges and back-to-back tvalid into
// request pulses, masks CC inside a packet and
// re-raises CFG when the link comes back up
//////////////////////////////////////////////////

`timescale 1ns/1ps

module arb_req_detect
  import arb_cfg_pkg::*, arb_types_pkg::*;
(
  input  logic          com_iclk,
  input  logic          com_sysrst,
  input  logic          rw_tvalid,
  input  logic          cc_tvalid,
  input  logic          cfg_tvalid,
  input  logic          rr_tvalid,
  input  logic          cc_tlast,
  input  logic          lnk_up,
  arb_sched_if.detect   sched
);

  req_vec_t tvalid_vec;   // Current tvalids in request order
  req_vec_t tvalid_q;     // Previous cycle tvalids
  req_vec_t sel_vec;      // Granted channel as one-hot
  req_vec_t edge_req;
  req_vec_t b2b_req;
  req_vec_t raw_req;
  logic     lnk_up_q;
  logic     cc_in_pkt;    // CC packet started, tlast not yet seen
  logic     cfg_relink;

  assign tvalid_vec[BIT_RW]  = rw_tvalid;
  assign tvalid_vec[BIT_CC]  = cc_tvalid;
  assign tvalid_vec[BIT_CFG] = cfg_tvalid;
  assign tvalid_vec[BIT_RR]  = rr_tvalid;

  // Edge detect history
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      tvalid_q <= '0;
      lnk_up_q <= 1'b0;
    end else begin
      tvalid_q <= tvalid_vec;
      lnk_up_q <= lnk_up;
    end
  end

  // CC in-packet tracking
  // A tvalid bubble mid-packet must not look like a new request
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      cc_in_pkt <= 1'b0;
    end else if (!lnk_up) begin
      cc_in_pkt <= 1'b0;            // Packet abandoned on link down
    end else if (cc_tvalid && !cc_tlast) begin
      cc_in_pkt <= 1'b1;
    end else if (cc_tlast) begin
      cc_in_pkt <= 1'b0;
    end
  end

  assign sel_vec  = sel_to_vec(sched.channel_sel);
  assign edge_req = tvalid_vec & ~tvalid_q;                          // Rising tvalid
  assign b2b_req  = {NUM_CH{sched.req_done}} & sel_vec & tvalid_vec; // Still valid after done
  assign raw_req  = edge_req | b2b_req;

  // CFG request lost to a link drop is raised again on relink
  assign cfg_relink = lnk_up && !lnk_up_q && cfg_tvalid && sched.psr_idle;

  always_comb begin
    sched.pkt_req          = raw_req;
    sched.pkt_req[BIT_CC]  = raw_req[BIT_CC] & ~cc_in_pkt;
    sched.pkt_req[BIT_CFG] = raw_req[BIT_CFG] | cfg_relink;
  end

endmodule : arb_req_detect

//--- rtl/arb_sched_if.sv
//////////////////////////////////////////////////
// TX arbiter scheduling interface
// Links request detection, the status register
// and queue, and the completion tracker
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface arb_sched_if
  import arb_types_pkg::*;
  ();

  req_vec_t pkt_req;      // New requests this cycle
  channel_e channel_sel;  // Channel currently granted
  logic     backlog;      // Other work still waiting
  logic     psr_idle;     // Status register empty
  logic     req_done;     // Selected packet finished last cycle

  // Request detector, needs grant and completion for back-to-back
  modport detect (
    output pkt_req,
    input  channel_sel,
    input  req_done,
    input  psr_idle
  );

  // Status register and request queue
  modport queue (
    input  pkt_req,
    input  req_done,
    output channel_sel,
    output backlog,
    output psr_idle
  );

  // Completion and throttle logic
  modport done (
    input  pkt_req,
    input  channel_sel,
    input  backlog,
    output req_done
  );

endinterface : arb_sched_if

//--- rtl/arb_types_pkg.sv
//////////////////////////////////////////////////
// TX arbiter types
// Channel select encoding and request vector type
//////////////////////////////////////////////////

package arb_types_pkg;
  import arb_cfg_pkg::*;

  // Channel select code seen by the TX pipeline
  typedef enum logic [1:0] {
    CH_CFG = 2'd0,
    CH_CC  = 2'd1,
    CH_RW  = 2'd2,
    CH_RR  = 2'd3
  } channel_e;

  // One request bit per channel, indexed by BIT_ constants
  typedef logic [NUM_CH-1:0] req_vec_t;

  // One-hot of the selected channel in request vector order
  function automatic req_vec_t sel_to_vec(channel_e ch);
    req_vec_t v;
    v = '0;
    case (ch)
      CH_RW:   v[BIT_RW]  = 1'b1;
      CH_CC:   v[BIT_CC]  = 1'b1;
      CH_CFG:  v[BIT_CFG] = 1'b1;
      default: v[BIT_RR]  = 1'b1;
    endcase
    return v;
  endfunction

endpackage : arb_types_pkg

//--- rtl/tx_arbiter_top.sv
//////////////////////////////////////////////////
// TX channel arbiter top
// Endpoint arbiter over the RW, CC, CFG and RR
// source channels
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tx_arbiter_top
  import arb_types_pkg::*;
(
  input  logic     com_iclk,
  input  logic     com_sysrst,
  input  logic     rw_tvalid,
  input  logic     cc_tvalid,
  input  logic     cfg_tvalid,
  input  logic     rr_tvalid,
  input  logic     rw_tlast,
  input  logic     cc_tlast,
  input  logic     cfg_tlast,
  input  logic     rr_tlast,
  input  logic     tx_tready,   // From the TX pipeline
  input  logic     lnk_up,
  output channel_e channel_sel,
  output logic     rr_thrtl,
  output logic     rw_thrtl,
  output logic     cc_thrtl
);

  arb_sched_if sched ();

  arb_req_detect arb_req_detect_i (
    .com_iclk   (com_iclk),
    .com_sysrst (com_sysrst),
    .rw_tvalid  (rw_tvalid),
    .cc_tvalid  (cc_tvalid),
    .cfg_tvalid (cfg_tvalid),
    .rr_tvalid  (rr_tvalid),
    .cc_tlast   (cc_tlast),
    .lnk_up     (lnk_up),
    .sched      (sched.detect)
  );

  arb_psr_queue arb_psr_queue_i (
    .com_iclk   (com_iclk),
    .com_sysrst (com_sysrst),
    .lnk_up     (lnk_up),
    .sched      (sched.queue)
  );

  arb_completion arb_completion_i (
    .com_iclk   (com_iclk),
    .com_sysrst (com_sysrst),
    .rw_tvalid  (rw_tvalid),
    .cc_tvalid  (cc_tvalid),
    .cfg_tvalid (cfg_tvalid),
    .rr_tvalid  (rr_tvalid),
    .rw_tlast   (rw_tlast),
    .cc_tlast   (cc_tlast),
    .cfg_tlast  (cfg_tlast),
    .rr_tlast   (rr_tlast),
    .tx_tready  (tx_tready),
    .sched      (sched.done),
    .rr_thrtl   (rr_thrtl),
    .rw_thrtl   (rw_thrtl),
    .cc_thrtl   (cc_thrtl)
  );

  assign channel_sel = sched.channel_sel;  // Grant out to the TX mux

endmodule : tx_arbiter_top

//--- run_sim.sh
#!/bin/sh
# Build and run the TX arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module arb_tb -o arb_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/arb_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- verif/arb_tb_model.svh
//////////////////////////////////////////////////
// TX arbiter reference model
// Cycle model of request detection, the status
// register, the request queue and throttle flags
//////////////////////////////////////////////////

req_vec_t m_tvq   = '0;            // tvalids seen at the last edge
req_vec_t m_psr   = '0;            // Pending request set
req_vec_t m_fifo [QUEUE_DEPTH];
int       m_rd    = 0;
int       m_wr    = 0;
logic     m_lnkq  = 1'b0;
logic     m_ccpkt = 1'b0;          // Inside a CC packet
logic     m_done  = 1'b0;
req_vec_t m_pkt;                   // Request pulses for the coming edge
channel_e m_sel;
logic     m_backlog;
logic     m_rw_thr;
logic     m_cc_thr;
logic     m_rr_thr;

// Request vector bit of a channel code
function automatic req_vec_t chan_onehot(channel_e c);
  return req_vec_t'(1) << (c == CH_RW ? BIT_RW : c == CH_CC ? BIT_CC :
                           c == CH_CFG ? BIT_CFG : BIT_RR);
endfunction

// Grant, request pulses and flags from state and current inputs
task automatic model_eval();
  if (m_psr[BIT_RW])       m_sel = CH_RW;
  else if (m_psr[BIT_CC])  m_sel = CH_CC;
  else if (m_psr[BIT_CFG]) m_sel = CH_CFG;
  else if (m_psr[BIT_RR])  m_sel = CH_RR;
  else                     m_sel = CH_RW;   // Idle default
  m_pkt = (tv & ~m_tvq) | ({NUM_CH{m_done}} & chan_onehot(m_sel) & tv);
  m_pkt[BIT_CC]  &= !m_ccpkt;
  m_pkt[BIT_CFG] |= lnk_up && !m_lnkq && tv[BIT_CFG] && (m_psr == '0);  // Relink
  m_backlog = (m_rd != m_wr) || ($countones(m_psr) > 1);
  m_rw_thr  = m_done && m_backlog && (m_sel == CH_RW) && m_pkt[BIT_RW];
  m_cc_thr  = m_done && m_backlog && (m_sel == CH_CC) && m_pkt[BIT_CC];
  m_rr_thr  = m_done && m_backlog && (m_sel == CH_RR) && m_pkt[BIT_RR];
endtask

// State update at the rising edge, call after model_eval
task automatic model_step();
  req_vec_t nxt;
  req_vec_t served;
  logic     single;
  logic     empty;
  logic     push;
  logic     pop;
  served = (m_sel == CH_RW || m_sel == CH_CC) ? chan_onehot(m_sel) : chan_onehot(CH_RR);
  single = ($countones(m_psr) == 1);
  empty  = (m_rd == m_wr);
  push   = (m_pkt != '0) && (!empty || ((m_psr != '0) && !(m_done && single)));
  pop    = 1'b0;
  nxt    = m_psr;
  if (m_done && !single && m_psr != '0) nxt = (lnk_up || !empty) ? (m_psr & ~served) : '0;
  else if (empty && (m_psr == '0 || (m_done && single))) nxt = m_pkt;
  else if (m_done && single) begin
    nxt = m_fifo[m_rd];            // Oldest queued set
    pop = 1'b1;
  end
  if (push) m_fifo[m_wr] = m_pkt;
  if (!lnk_up) begin
    m_rd = 0;
    m_wr = 0;
  end else begin
    if (pop)  m_rd = (m_rd + 1) % QUEUE_DEPTH;
    if (push) m_wr = (m_wr + 1) % QUEUE_DEPTH;
  end
  if (!lnk_up) m_ccpkt = 1'b0;
  else if (tv[BIT_CC] && !tl[BIT_CC]) m_ccpkt = 1'b1;
  else if (tl[BIT_CC]) m_ccpkt = 1'b0;
  m_done = tready && ((chan_onehot(m_sel) & tv & tl) != '0);   // Last beat taken
  m_psr  = nxt;
  m_tvq  = tv;
  m_lnkq = lnk_up;
  if (com_sysrst) begin
    m_psr = '0;  m_rd = 0;  m_wr = 0;
    m_done = 1'b0;  m_ccpkt = 1'b0;  m_tvq = '0;  m_lnkq = 1'b0;
  end
endtask

task automatic check_flag(string name, logic got, logic exp);
  assert (got === exp) else begin
    errors++;
    $display("FAIL %0t %0s got %b exp %b", $time, name, got, exp);
  end
endtask

task automatic compare_outputs();
  checks++;
  assert (channel_sel === m_sel) else begin
    errors++;
    $display("FAIL %0t channel_sel got %0d exp %0d", $time, channel_sel, m_sel);
  end
  check_flag("rw_thrtl", rw_thrtl, m_rw_thr);
  check_flag("cc_thrtl", cc_thrtl, m_cc_thr);
  check_flag("rr_thrtl", rr_thrtl, m_rr_thr);
endtask

//--- verif/arb_tb.sv
//////////////////////////////////////////////////
// TX arbiter testbench
// Directed and xorshift traffic on the four source
// channels, checked every cycle against a model
//////////////////////////////////////////////////

`timescale 1ns/1ps

module arb_tb
  import arb_cfg_pkg::*, arb_types_pkg::*;
();

  localparam int RST_CYC   = 10;
  localparam int T_SINGLE  = 100;
  localparam int T_PRIO    = 40;
  localparam int T_QUEUE   = 400;
  localparam int T_B2B     = 400;
  localparam int T_LINK    = 80;
  localparam int T_RAND    = 3000;
  localparam int CYC_LIMIT = 6 * RST_CYC + T_SINGLE + T_PRIO + T_QUEUE + T_B2B
                             + T_LINK + T_RAND + 200;

  logic        com_iclk;
  logic        com_sysrst;
  req_vec_t    tv;               // tvalid per channel in BIT_ order
  req_vec_t    tl;               // tlast per channel
  logic        tready;
  logic        lnk_up;
  channel_e    channel_sel;
  logic        rr_thrtl;
  logic        rw_thrtl;
  logic        cc_thrtl;
  int          beats [NUM_CH];   // Beats left in each source packet
  req_vec_t    hold = '0;        // Forced tvalid bubble
  logic        lnk = 1'b1;
  int          p_start, p_ready, p_b2b, p_bub, p_down;   // Chances out of 16 or 64
  logic [31:0] rng = 32'ha2f5c1c1;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          cyc;

  `include "arb_tb_model.svh"

  tx_arbiter_top tx_arbiter_top_i (
    .com_iclk    (com_iclk),
    .com_sysrst  (com_sysrst),
    .rw_tvalid   (tv[BIT_RW]),
    .cc_tvalid   (tv[BIT_CC]),
    .cfg_tvalid  (tv[BIT_CFG]),
    .rr_tvalid   (tv[BIT_RR]),
    .rw_tlast    (tl[BIT_RW]),
    .cc_tlast    (tl[BIT_CC]),
    .cfg_tlast   (tl[BIT_CFG]),
    .rr_tlast    (tl[BIT_RR]),
    .tx_tready   (tready),
    .lnk_up      (lnk_up),
    .channel_sel (channel_sel),
    .rr_thrtl    (rr_thrtl),
    .rw_thrtl    (rw_thrtl),
    .cc_thrtl    (cc_thrtl)
  );

  initial begin
    com_iclk = 1'b0;
    forever #5 com_iclk = ~com_iclk;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  function automatic int roll(int n);
    rng = xorshift32(rng);
    return int'(rng % n);
  endfunction

  task automatic set_traffic(int s, int r, int b, int bub, int dn);
    p_start = s;
    p_ready = r;
    p_b2b   = b;
    p_bub   = bub;
    p_down  = dn;
  endtask

  // Drive pins from the source state
  task automatic apply_inputs();
    for (int i = 0; i < NUM_CH; i++) begin
      tv[i] = (beats[i] != 0) && !hold[i];
      tl[i] = (beats[i] == 1);
    end
    tready = roll(16) < p_ready;
    lnk_up = lnk && (roll(64) >= p_down);   // Short link blips
  endtask

  // One clock with outputs checked on the inputs now applied
  task automatic clock_cycle();
    req_vec_t acc;
    req_vec_t fin;
    #1;
    model_eval();                                 // Same inputs the next edge samples
    if (!com_sysrst) begin
      compare_outputs();
    end
    @(negedge com_iclk);
    acc = chan_onehot(m_sel) & tv & {NUM_CH{tready}};   // Beats taken at the edge just passed
    fin = '0;
    for (int i = 0; i < NUM_CH; i++) begin
      if (acc[i]) begin
        beats[i]--;
        fin[i] = (beats[i] == 0);
      end
    end
    model_step();
    for (int i = 0; i < NUM_CH; i++) begin
      if (beats[i] == 0 && roll(16) < (fin[i] ? p_b2b : p_start)) beats[i] = 1 + roll(4);
      if (p_bub != 0) hold[i] = roll(16) < p_bub;
    end
    apply_inputs();
  endtask

  task automatic reset_dut();
    com_sysrst = 1'b1;
    hold = '0;
    lnk = 1'b1;
    set_traffic(0, 0, 0, 0, 0);
    foreach (beats[i]) beats[i] = 0;
    apply_inputs();
    repeat (RST_CYC) clock_cycle();
    com_sysrst = 1'b0;
  endtask

  task automatic wait_idle(int ch, int limit);
    int n;
    n = 0;
    while (beats[ch] != 0 && n < limit) begin
      clock_cycle();
      n++;
    end
    assert (beats[ch] == 0) else begin
      errors++;
      $display("channel %0d packet not accepted within %0d cycles", ch, limit);
    end
  endtask

  task automatic finish_test(string name, int err0);
    tests++;
    $display("test %0s finished with %0d errors", name, errors - err0);
  endtask

  task automatic run_random(string name, int s, int r, int b, int bub, int dn, int n);
    int err0;
    reset_dut();
    err0 = errors;
    set_traffic(s, r, b, bub, dn);
    repeat (n) clock_cycle();
    finish_test(name, err0);
  endtask

  // CC bubble mid-packet and a queued CFG lost on link down and raised on relink
  task automatic cc_link_test();
    int err0;
    int n;
    reset_dut();
    err0 = errors;
    set_traffic(0, 16, 0, 0, 0);
    beats[BIT_CC] = 4;
    apply_inputs();
    repeat (2) clock_cycle();
    hold[BIT_CC] = 1'b1;
    apply_inputs();
    repeat (2) clock_cycle();
    hold[BIT_CC] = 1'b0;          // Rising again inside the packet
    apply_inputs();
    wait_idle(BIT_CC, 20);
    set_traffic(0, 0, 0, 0, 0);   // Stall RW so CFG goes to the queue
    beats[BIT_RW] = 3;
    apply_inputs();
    repeat (2) clock_cycle();
    beats[BIT_CFG] = 2;
    apply_inputs();
    repeat (2) clock_cycle();
    lnk = 1'b0;
    apply_inputs();
    repeat (2) clock_cycle();
    set_traffic(0, 16, 0, 0, 0);
    apply_inputs();
    wait_idle(BIT_RW, 10);
    repeat (2) clock_cycle();     // Status register drains
    lnk = 1'b1;
    apply_inputs();
    n = 0;
    while (channel_sel != CH_CFG && n < 5) begin
      clock_cycle();
      n++;
    end
    assert (channel_sel == CH_CFG) else begin
      errors++;
      $display("CFG was not selected again after link up");
    end
    wait_idle(BIT_CFG, 10);
    finish_test("cc_link", err0);
  endtask

  initial begin
    int err0;
    com_sysrst = 1'b1;
    tv = '0;
    tl = '0;
    tready = 1'b0;
    lnk_up = 1'b1;
    reset_dut();
    err0 = errors;
    set_traffic(0, 16, 0, 0, 0);
    foreach (beats[ch]) begin     // One channel at a time
      beats[ch] = 2;
      apply_inputs();
      wait_idle(ch, 20);
      repeat (3) clock_cycle();
    end
    finish_test("single", err0);
    reset_dut();
    err0 = errors;
    set_traffic(0, 16, 0, 0, 0);
    foreach (beats[ch]) beats[ch] = 1 + ch % 2;   // All rise together
    apply_inputs();
    repeat (T_PRIO) clock_cycle();
    finish_test("priority", err0);
    run_random("queued", 2, 8, 0, 0, 0, T_QUEUE);
    run_random("b2b", 2, 12, 12, 0, 0, T_B2B);
    cc_link_test();
    run_random("random", 4, 10, 6, 2, 2, T_RAND);
    $display("%0d tests run, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Run length guard
  initial begin
    cyc = 0;
    while (cyc < CYC_LIMIT) begin
      @(posedge com_iclk);
      cyc++;
    end
    $display("run stopped after %0d cycles without finishing", cyc);
    $display("*** FAILED ***");
    $finish;
  end

endmodule : arb_tb
